// File: Makefile
# Verilator flow for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isa_pkg::alu_op_t op,
    input  isa_pkg::word_t   src1,
    input  isa_pkg::word_t   src2,
    output isa_pkg::word_t   result,
    output logic             overflow
);

    isa_pkg::word_t sum;
    isa_pkg::word_t diff;
    logic [4:0]     shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign shamt       = src1[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            isa_pkg::alu_add,
            isa_pkg::alu_addu: result = sum;
            isa_pkg::alu_sub,
            isa_pkg::alu_subu: result = diff;
            isa_pkg::alu_slt:  result = isa_pkg::word_t'(lt_signed);
            isa_pkg::alu_sltu: result = isa_pkg::word_t'(lt_unsigned);
            isa_pkg::alu_and:  result = src1 & src2;
            isa_pkg::alu_or:   result = src1 | src2;
            isa_pkg::alu_xor:  result = src1 ^ src2;
            isa_pkg::alu_nor:  result = ~(src1 | src2);
            isa_pkg::alu_sll:  result = src2 << shamt;
            isa_pkg::alu_srl:  result = src2 >> shamt;
            isa_pkg::alu_sra:  result = isa_pkg::word_t'($signed(src2) >>> shamt);
            isa_pkg::alu_lui:  result = {src2[15:0], 16'h0000};
            default:           result = sum;
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (op)
            isa_pkg::alu_add: begin
                overflow = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            end
            isa_pkg::alu_sub: begin
                overflow = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            end
            default: begin
                overflow = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: compile.f
isa_pkg.sv
sram_pkg.sv
alu.sv
mem_align.sv
sram_request.sv
hilo_unit.sv
exe_stage.sv
exe_stage_asserts.sv
tb_exe_stage.sv

// File: exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  isa_pkg::alu_op_t     in_alu_op,
    input  isa_pkg::src1_sel_t   in_src1_sel,
    input  isa_pkg::src2_sel_t   in_src2_sel,
    input  isa_pkg::mem_op_t     in_mem_op,
    input  isa_pkg::hilo_op_t    in_hilo_op,
    input  logic                 in_gr_we,
    input  isa_pkg::reg_addr_t   in_dest,
    input  isa_pkg::imm_t        in_imm,
    input  isa_pkg::word_t       in_rs_value,
    input  isa_pkg::word_t       in_rt_value,
    input  isa_pkg::word_t       in_pc,
    output logic                 out_valid,
    input  logic                 out_ready,
    output isa_pkg::word_t       out_result,
    output isa_pkg::reg_addr_t   out_dest,
    output logic                 out_gr_we,
    output isa_pkg::mem_op_t     out_mem_op,
    output isa_pkg::word_t       out_pc,
    output isa_pkg::excode_t     out_excode,
    output isa_pkg::word_t       out_badvaddr,
    output logic                 data_sram_en,
    output logic                 data_sram_wr,
    output sram_pkg::sram_size_t data_sram_size,
    output sram_pkg::wstrb_t     data_sram_wstrb,
    output isa_pkg::word_t       data_sram_addr,
    output isa_pkg::word_t       data_sram_wdata,
    input  logic                 data_sram_addr_ok
);

    logic               valid;
    isa_pkg::alu_op_t   alu_op;
    isa_pkg::src1_sel_t src1_sel;
    isa_pkg::src2_sel_t src2_sel;
    isa_pkg::mem_op_t   mem_op;
    isa_pkg::hilo_op_t  hilo_op;
    logic               gr_we;
    isa_pkg::reg_addr_t dest;
    isa_pkg::imm_t      imm;
    isa_pkg::word_t     rs_value;
    isa_pkg::word_t     rt_value;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     src1;
    isa_pkg::word_t     src2;
    isa_pkg::word_t     alu_result;
    isa_pkg::word_t     hilo_value;
    isa_pkg::excode_t   excode;
    logic               overflow;
    logic               load_error;
    logic               store_error;
    logic               need_req;
    logic               ready_go;
    logic               leave;

    assign out_valid = valid && ready_go;
    assign in_ready  = !valid || (ready_go && out_ready);
    assign leave     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= 1'b0;
            alu_op   <= isa_pkg::alu_addu;
            src1_sel <= isa_pkg::src1_rs;
            src2_sel <= isa_pkg::src2_rt;
            mem_op   <= isa_pkg::mem_none;
            hilo_op  <= isa_pkg::hilo_none;
            gr_we    <= 1'b0;
        end else if (in_ready) begin
            valid <= in_valid;
            if (in_valid) begin
                alu_op   <= in_alu_op;
                src1_sel <= in_src1_sel;
                src2_sel <= in_src2_sel;
                mem_op   <= in_mem_op;
                hilo_op  <= in_hilo_op;
                gr_we    <= in_gr_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dest     <= in_dest;
            imm      <= in_imm;
            rs_value <= in_rs_value;
            rt_value <= in_rt_value;
            pc       <= in_pc;
        end
    end

    always_comb begin
        case (src1_sel)
            isa_pkg::src1_sa: src1 = isa_pkg::word_t'(imm[10:6]);
            isa_pkg::src1_pc: src1 = pc;
            default:          src1 = rs_value;
        endcase
        case (src2_sel)
            isa_pkg::src2_simm:   src2 = {{16{imm[15]}}, imm};
            isa_pkg::src2_zimm:   src2 = {16'h0000, imm};
            isa_pkg::src2_const8: src2 = 32'd8;
            default:              src2 = rt_value;
        endcase
    end

    alu u_alu (
        .op       (alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (overflow)
    );

    mem_align u_mem_align (
        .mem_op      (mem_op),
        .addr        (alu_result),
        .rt_value    (rt_value),
        .load_error  (load_error),
        .store_error (store_error),
        .wstrb       (data_sram_wstrb),
        .wdata       (data_sram_wdata)
    );

    // ov wins over address errors
    assign excode = overflow    ? isa_pkg::ex_ov   :
                    load_error  ? isa_pkg::ex_adel :
                    store_error ? isa_pkg::ex_ades :
                                  isa_pkg::ex_none;

    assign need_req = (mem_op != isa_pkg::mem_none) && (excode == isa_pkg::ex_none);

    sram_request u_sram_request (
        .clk      (clk),
        .reset    (reset),
        .active   (valid && need_req),
        .leave    (leave),
        .addr_ok  (data_sram_addr_ok),
        .en       (data_sram_en),
        .ready_go (ready_go)
    );

    hilo_unit u_hilo_unit (
        .clk        (clk),
        .reset      (reset),
        .op         (hilo_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .commit     (leave && (excode == isa_pkg::ex_none)),
        .read_value (hilo_value)
    );

    assign data_sram_wr   = (mem_op == isa_pkg::mem_sw) || (mem_op == isa_pkg::mem_sh) ||
                            (mem_op == isa_pkg::mem_sb);
    assign data_sram_size = sram_pkg::SRAM_SIZE_WORD;
    assign data_sram_addr = alu_result;

    assign out_result   = (hilo_op == isa_pkg::hilo_mfhi || hilo_op == isa_pkg::hilo_mflo) ?
                          hilo_value : alu_result;
    assign out_dest     = dest;
    assign out_gr_we    = gr_we;
    assign out_mem_op   = mem_op;
    assign out_pc       = pc;
    assign out_excode   = excode;
    assign out_badvaddr = (excode == isa_pkg::ex_adel || excode == isa_pkg::ex_ades) ?
                          alu_result : '0;

endmodule

`default_nettype wire

// File: exe_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 valid,
    input isa_pkg::mem_op_t     mem_op,
    input isa_pkg::word_t       rt_value,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input isa_pkg::word_t       out_result,
    input isa_pkg::reg_addr_t   out_dest,
    input logic                 out_gr_we,
    input isa_pkg::mem_op_t     out_mem_op,
    input isa_pkg::word_t       out_pc,
    input isa_pkg::excode_t     out_excode,
    input isa_pkg::word_t       out_badvaddr,
    input logic                 data_sram_en,
    input sram_pkg::wstrb_t     data_sram_wstrb,
    input isa_pkg::word_t       data_sram_addr,
    input isa_pkg::word_t       data_sram_wdata,
    input logic                 data_sram_addr_ok
);

    logic is_load;
    logic leave;

    assign is_load  = mem_op inside {isa_pkg::mem_lw, isa_pkg::mem_lh, isa_pkg::mem_lhu,
                                     isa_pkg::mem_lb, isa_pkg::mem_lbu};
    assign leave    = out_valid && out_ready;

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !out_valid && !data_sram_en && in_ready)
        else $error("stage is not idle in the first cycle after reset");

    // overflow and address errors never reach the SRAM
    no_request_on_exception: assert property (@(posedge clk) disable iff (reset)
        (valid && out_excode != isa_pkg::ex_none) |-> !data_sram_en)
        else $error("SRAM request raised for an instruction with an exception");

    load_no_strobes: assert property (@(posedge clk) disable iff (reset)
        (valid && is_load) |-> data_sram_wstrb == 4'b0000)
        else $error("load drives non-zero write strobes");

    sb_format: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && mem_op == isa_pkg::mem_sb) |->
            data_sram_wstrb == (4'b0001 << data_sram_addr[1:0]) &&
            data_sram_wdata == {4{rt_value[7:0]}})
        else $error("byte store has wrong strobes or data");

    sh_format: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && mem_op == isa_pkg::mem_sh) |->
            data_sram_wstrb == (data_sram_addr[1] ? 4'b1100 : 4'b0011) &&
            data_sram_wdata == {2{rt_value[15:0]}})
        else $error("halfword store has wrong strobes or data");

    sw_format: assert property (@(posedge clk) disable iff (reset)
        (data_sram_en && mem_op == isa_pkg::mem_sw) |->
            data_sram_wstrb == 4'b1111 && data_sram_wdata == rt_value)
        else $error("word store has wrong strobes or data");

    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_result) &&
            $stable(out_dest) && $stable(out_gr_we) && $stable(out_mem_op) &&
            $stable(out_pc) && $stable(out_excode) && $stable(out_badvaddr))
        else $error("outputs changed while held by the next stage");

    // a held instruction keeps en low once its address went out
    no_second_request: assert property (@(posedge clk) disable iff (reset)
        (valid && !leave && (!data_sram_en || data_sram_addr_ok)) |=> !data_sram_en)
        else $error("SRAM request raised again after its address was accepted");

endmodule

`default_nettype wire

// File: hilo_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_unit (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::hilo_op_t op,
    input  isa_pkg::word_t    rs_value,
    input  isa_pkg::word_t    rt_value,
    input  logic              commit,
    output isa_pkg::word_t    read_value
);

    isa_pkg::word_t               hi;
    isa_pkg::word_t               lo;
    logic [2*isa_pkg::WORD_W-1:0] prod_signed;
    logic [2*isa_pkg::WORD_W-1:0] prod_unsigned;

    // operands widen to 64 bits before the multiply
    assign prod_signed   = $signed(rs_value) * $signed(rt_value);
    assign prod_unsigned = rs_value * rt_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (op)
                isa_pkg::hilo_mthi: begin
                    hi <= rs_value;
                end
                isa_pkg::hilo_mtlo: begin
                    lo <= rs_value;
                end
                isa_pkg::hilo_mult: begin
                    {hi, lo} <= prod_signed;
                end
                isa_pkg::hilo_multu: begin
                    {hi, lo} <= prod_unsigned;
                end
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // registered values, so a read right after a write sees it
    assign read_value = (op == isa_pkg::hilo_mfhi) ? hi : lo;

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]      imm_t;

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_lui
    } alu_op_t;

    // sa takes instruction bits 10..6 from the immediate
    typedef enum logic [1:0] {
        src1_rs, src1_sa, src1_pc
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rt, src2_simm, src2_zimm, src2_const8
    } src2_sel_t;

    typedef enum logic [3:0] {
        mem_none, mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu, mem_sw, mem_sh, mem_sb
    } mem_op_t;

    typedef enum logic [2:0] {
        hilo_none, hilo_mfhi, hilo_mflo, hilo_mthi, hilo_mtlo, hilo_mult, hilo_multu
    } hilo_op_t;

    // cp0 cause codes, none sits outside the architected range
    typedef enum logic [4:0] {
        ex_adel = 5'h04,
        ex_ades = 5'h05,
        ex_ov   = 5'h0c,
        ex_none = 5'h1f
    } excode_t;

endpackage

`default_nettype wire

// File: mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align (
    input  isa_pkg::mem_op_t mem_op,
    input  isa_pkg::word_t   addr,
    input  isa_pkg::word_t   rt_value,
    output logic             load_error,
    output logic             store_error,
    output sram_pkg::wstrb_t wstrb,
    output isa_pkg::word_t   wdata
);

    sram_pkg::byte_offset_t offset;
    logic                   word_misaligned;
    logic                   half_misaligned;

    assign offset          = addr[1:0];
    assign word_misaligned = offset != 2'b00;
    assign half_misaligned = offset[0];

    // byte accesses can never be misaligned
    always_comb begin
        load_error  = 1'b0;
        store_error = 1'b0;
        case (mem_op)
            isa_pkg::mem_lw: begin
                load_error = word_misaligned;
            end
            isa_pkg::mem_lh,
            isa_pkg::mem_lhu: begin
                load_error = half_misaligned;
            end
            isa_pkg::mem_sw: begin
                store_error = word_misaligned;
            end
            isa_pkg::mem_sh: begin
                store_error = half_misaligned;
            end
            default: begin
                load_error  = 1'b0;
                store_error = 1'b0;
            end
        endcase
    end

    // replicate so every lane carries the store value
    always_comb begin
        case (mem_op)
            isa_pkg::mem_sb: wdata = {4{rt_value[7:0]}};
            isa_pkg::mem_sh: wdata = {2{rt_value[15:0]}};
            default:         wdata = rt_value;
        endcase
    end

    always_comb begin
        case (mem_op)
            isa_pkg::mem_sb: wstrb = sram_pkg::wstrb_t'(4'b0001 << offset);
            isa_pkg::mem_sh: wstrb = offset[1] ? 4'b1100 : 4'b0011;
            isa_pkg::mem_sw: wstrb = 4'b1111;
            default:         wstrb = 4'b0000;
        endcase
        if (store_error) begin
            wstrb = 4'b0000;
        end
    end

endmodule

`default_nettype wire

// File: sram_pkg.sv
`default_nettype none

package sram_pkg;

    localparam int OFFSET_W = 2;
    localparam int WSTRB_W  = 4;
    localparam int SIZE_W   = 2;

    typedef logic [OFFSET_W-1:0] byte_offset_t;
    typedef logic [WSTRB_W-1:0]  wstrb_t;
    typedef logic [SIZE_W-1:0]   sram_size_t;

    // sub-word stores are expressed through the strobes
    localparam sram_size_t SRAM_SIZE_WORD = 2'd2;

    typedef enum logic {
        req_idle, req_accepted
    } sram_req_state_t;

endpackage

`default_nettype wire

// File: sram_request.sv
`timescale 1ns/1ps
`default_nettype none

module sram_request (
    input  logic clk,
    input  logic reset,
    input  logic active,
    input  logic leave,
    input  logic addr_ok,
    output logic en,
    output logic ready_go
);

    sram_pkg::sram_req_state_t state;
    sram_pkg::sram_req_state_t state_next;

    assign en       = active && (state == sram_pkg::req_idle);
    assign ready_go = !active || (en && addr_ok) || (state == sram_pkg::req_accepted);

    // accepted only matters while the instruction is held back
    always_comb begin
        state_next = state;
        case (state)
            sram_pkg::req_idle: begin
                if (en && addr_ok && !leave) begin
                    state_next = sram_pkg::req_accepted;
                end
            end
            sram_pkg::req_accepted: begin
                if (leave) begin
                    state_next = sram_pkg::req_idle;
                end
            end
            default: begin
                state_next = sram_pkg::req_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sram_pkg::req_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: tb_exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_stage;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 5;
    localparam int N_INSTR          = 400;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int WATCHDOG_NS      = N_INSTR * CYCLES_PER_INSTR * CLK_PERIOD;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::src1_sel_t src1_sel;
        isa_pkg::src2_sel_t src2_sel;
        isa_pkg::mem_op_t   mem_op;
        isa_pkg::hilo_op_t  hilo_op;
        logic               gr_we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::imm_t      imm;
        isa_pkg::word_t     rs_value;
        isa_pkg::word_t     rt_value;
        isa_pkg::word_t     pc;
    } instr_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    instr_t               drive;
    logic                 out_valid;
    logic                 out_ready;
    isa_pkg::word_t       out_result;
    isa_pkg::reg_addr_t   out_dest;
    logic                 out_gr_we;
    isa_pkg::mem_op_t     out_mem_op;
    isa_pkg::word_t       out_pc;
    isa_pkg::excode_t     out_excode;
    isa_pkg::word_t       out_badvaddr;
    logic                 data_sram_en;
    logic                 data_sram_wr;
    sram_pkg::sram_size_t data_sram_size;
    sram_pkg::wstrb_t     data_sram_wstrb;
    isa_pkg::word_t       data_sram_addr;
    isa_pkg::word_t       data_sram_wdata;
    logic                 data_sram_addr_ok;

    integer         seed;
    instr_t         pending[$];
    isa_pkg::word_t model_hi;
    isa_pkg::word_t model_lo;
    int             accepted;
    int             departures;
    int             mismatches;
    logic           transferred;

    exe_stage i_dut (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_alu_op         (drive.alu_op),
        .in_src1_sel       (drive.src1_sel),
        .in_src2_sel       (drive.src2_sel),
        .in_mem_op         (drive.mem_op),
        .in_hilo_op        (drive.hilo_op),
        .in_gr_we          (drive.gr_we),
        .in_dest           (drive.dest),
        .in_imm            (drive.imm),
        .in_rs_value       (drive.rs_value),
        .in_rt_value       (drive.rt_value),
        .in_pc             (drive.pc),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_result        (out_result),
        .out_dest          (out_dest),
        .out_gr_we         (out_gr_we),
        .out_mem_op        (out_mem_op),
        .out_pc            (out_pc),
        .out_excode        (out_excode),
        .out_badvaddr      (out_badvaddr),
        .data_sram_en      (data_sram_en),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    bind exe_stage exe_stage_asserts u_asserts (
        .clk               (clk),
        .reset             (reset),
        .valid             (valid),
        .mem_op            (mem_op),
        .rt_value          (rt_value),
        .in_ready          (in_ready),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_result        (out_result),
        .out_dest          (out_dest),
        .out_gr_we         (out_gr_we),
        .out_mem_op        (out_mem_op),
        .out_pc            (out_pc),
        .out_excode        (out_excode),
        .out_badvaddr      (out_badvaddr),
        .data_sram_en      (data_sram_en),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    // reference ALU written from the instruction set rules
    function automatic isa_pkg::word_t alu_model(isa_pkg::alu_op_t op, isa_pkg::word_t a,
                                                 isa_pkg::word_t b);
        case (op)
            isa_pkg::alu_add, isa_pkg::alu_addu: return a + b;
            isa_pkg::alu_sub, isa_pkg::alu_subu: return a + ~b + 32'd1;
            isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            isa_pkg::alu_and:  return a & b;
            isa_pkg::alu_or:   return a | b;
            isa_pkg::alu_xor:  return a ^ b;
            isa_pkg::alu_nor:  return ~(a | b);
            isa_pkg::alu_sll:  return b << a[4:0];
            isa_pkg::alu_srl:  return b >> a[4:0];
            isa_pkg::alu_sra:  return isa_pkg::word_t'($signed(b) >>> a[4:0]);
            default:           return {b[15:0], 16'h0000};
        endcase
    endfunction

    // 33-bit sign-extended sum, overflow when the top two bits differ
    function automatic logic overflow_model(isa_pkg::alu_op_t op, isa_pkg::word_t a,
                                            isa_pkg::word_t b);
        logic [32:0] wide;
        if (op == isa_pkg::alu_add) begin
            wide = {a[31], a} + {b[31], b};
        end else if (op == isa_pkg::alu_sub) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            wide = 33'd0;
        end
        return wide[32] != wide[31];
    endfunction

    task automatic compare(string what, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got,
                     expected);
            mismatches++;
        end
    endtask

    task automatic check_departure();
        instr_t           i;
        isa_pkg::word_t   a;
        isa_pkg::word_t   b;
        isa_pkg::word_t   res;
        logic             bad;
        logic             is_store;
        isa_pkg::excode_t exp_ex;
        logic [63:0]      prod;
        if (pending.size() == 0) begin
            $display("error at %0t ns: instruction left without being accepted", $time);
            mismatches++;
            return;
        end
        i = pending.pop_front();
        departures++;
        a = (i.src1_sel == isa_pkg::src1_sa) ? {27'd0, i.imm[10:6]} :
            (i.src1_sel == isa_pkg::src1_pc) ? i.pc : i.rs_value;
        case (i.src2_sel)
            isa_pkg::src2_simm:   b = {{16{i.imm[15]}}, i.imm};
            isa_pkg::src2_zimm:   b = {16'h0000, i.imm};
            isa_pkg::src2_const8: b = 32'd8;
            default:              b = i.rt_value;
        endcase
        res = alu_model(i.alu_op, a, b);
        case (i.mem_op)
            isa_pkg::mem_lw, isa_pkg::mem_sw: bad = res[1:0] != 2'b00;
            isa_pkg::mem_lh, isa_pkg::mem_lhu, isa_pkg::mem_sh: bad = res[0];
            default: bad = 1'b0;
        endcase
        is_store = i.mem_op inside {isa_pkg::mem_sw, isa_pkg::mem_sh, isa_pkg::mem_sb};
        if (overflow_model(i.alu_op, a, b)) begin
            exp_ex = isa_pkg::ex_ov;
        end else if (bad) begin
            exp_ex = is_store ? isa_pkg::ex_ades : isa_pkg::ex_adel;
        end else begin
            exp_ex = isa_pkg::ex_none;
        end
        if (i.hilo_op == isa_pkg::hilo_mfhi) begin
            compare("out_result", out_result, model_hi);
        end else if (i.hilo_op == isa_pkg::hilo_mflo) begin
            compare("out_result", out_result, model_lo);
        end else begin
            compare("out_result", out_result, res);
        end
        compare("out_dest", 32'(out_dest), 32'(i.dest));
        compare("out_gr_we", 32'(out_gr_we), 32'(i.gr_we));
        compare("out_mem_op", 32'(out_mem_op), 32'(i.mem_op));
        compare("out_pc", out_pc, i.pc);
        compare("out_excode", 32'(out_excode), 32'(exp_ex));
        compare("out_badvaddr", out_badvaddr,
                (exp_ex == isa_pkg::ex_adel || exp_ex == isa_pkg::ex_ades) ? res : 32'd0);
        compare("data_sram_addr", data_sram_addr, res);
        compare("data_sram_wr", 32'(data_sram_wr), 32'(is_store));
        // size code 2 is a four-byte access
        compare("data_sram_size", 32'(data_sram_size), 32'd2);
        // HI/LO only move for an instruction without exception
        if (exp_ex == isa_pkg::ex_none) begin
            prod = 64'd0;
            if (i.hilo_op == isa_pkg::hilo_mult) begin
                prod = {{32{i.rs_value[31]}}, i.rs_value} * {{32{i.rt_value[31]}}, i.rt_value};
            end else if (i.hilo_op == isa_pkg::hilo_multu) begin
                prod = {32'd0, i.rs_value} * {32'd0, i.rt_value};
            end
            case (i.hilo_op)
                isa_pkg::hilo_mthi: model_hi = i.rs_value;
                isa_pkg::hilo_mtlo: model_lo = i.rs_value;
                isa_pkg::hilo_mult, isa_pkg::hilo_multu: {model_hi, model_lo} = prod;
                default: model_hi = model_hi;
            endcase
        end
    endtask

    always @(posedge clk) begin
        transferred <= 1'b0;
        if (!reset) begin
            if (out_valid && out_ready) begin
                check_departure();
            end
            if (in_valid && in_ready) begin
                pending.push_back(drive);
                accepted++;
                transferred <= 1'b1;
            end
        end
    end

    // a stalled upstream instruction holds its fields
    task automatic drive_cycle();
        if (!in_valid || transferred) begin
            in_valid       = rand_below(10) < 7;
            drive.alu_op   = isa_pkg::alu_op_t'(4'(rand_below(14)));
            drive.src1_sel = isa_pkg::src1_sel_t'(2'(rand_below(3)));
            drive.src2_sel = isa_pkg::src2_sel_t'(2'(rand_below(4)));
            drive.mem_op   = isa_pkg::mem_op_t'(4'(rand_below(9)));
            drive.hilo_op  = isa_pkg::hilo_op_t'(3'(rand_below(7)));
            drive.gr_we    = rand_below(2) == 1;
            drive.dest     = 5'(rand_below(32));
            drive.imm      = 16'($random(seed));
            drive.rs_value = $random(seed);
            drive.rt_value = $random(seed);
            drive.pc       = $random(seed) & 32'hffff_fffc;
        end
        out_ready         = rand_below(10) < 6;
        data_sram_addr_ok = rand_below(2) == 1;
    endtask

    initial begin
        seed              = 32'hc6ad_df23;
        reset             = 1'b1;
        in_valid          = 1'b0;
        out_ready         = 1'b0;
        data_sram_addr_ok = 1'b0;
        drive             = '0;
        model_hi          = '0;
        model_lo          = '0;
        accepted          = 0;
        departures        = 0;
        mismatches        = 0;
        transferred       = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (accepted < N_INSTR) begin
            drive_cycle();
            @(negedge clk);
        end
        in_valid = 1'b0;
        // drain what is still in the stage
        while (departures < accepted) begin
            out_ready         = rand_below(10) < 6;
            data_sram_addr_ok = rand_below(2) == 1;
            @(negedge clk);
        end
        $display("mismatches %0d, departures %0d", mismatches, departures);
        if (mismatches == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run hung with %0d of %0d instructions departed", departures,
                 accepted);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
